//--- Bender.yml
package:
  name: mesh_router_buffered

sources:
  - design/mesh_router_pkg.sv
  - design/mesh_link_ingress.sv
  - design/mesh_input_fifo.sv
  - design/mesh_route_arbiter.sv
  - design/mesh_router_buffered.sv
  - target: test
    files:
      - testbench/mesh_router_buffered_props.sv
      - testbench/mesh_router_buffered_tb.sv

//--- design/mesh_input_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mesh input fifo
// small circular buffer, ready/valid in, valid/yumi out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mesh_input_fifo #(
   parameter int width_p = 16,
   parameter int els_p = 2
) (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               v_i,
   input  logic [width_p-1:0] data_i,
   output logic               ready_o,
   output logic               v_o,
   output logic [width_p-1:0] data_o,
   input  logic               yumi_i
);

   localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
   localparam int cnt_w_lp = $clog2(els_p + 1);

   logic [width_p-1:0]  mem_r [els_p];
   logic [ptr_w_lp-1:0] rd_ptr_r;
   logic [ptr_w_lp-1:0] wr_ptr_r;
   logic [cnt_w_lp-1:0] count_r;
   logic                enq;
   logic                deq;

   // pointers wrap at els_p, not at a power of two
   function automatic logic [ptr_w_lp-1:0] ptr_next_f(input logic [ptr_w_lp-1:0] ptr);
      if (ptr == ptr_w_lp'(els_p - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign ready_o = (count_r != cnt_w_lp'(els_p));
   assign v_o     = (count_r != '0);
   assign data_o  = mem_r[rd_ptr_r];

   assign enq = v_i & ready_o;
   assign deq = yumi_i;

   always_ff @(posedge clk_i) begin
      if (!reset_i) begin
         rd_ptr_r <= '0;
         wr_ptr_r <= '0;
         count_r  <= '0;
      end else begin
         if (enq) begin
            wr_ptr_r <= ptr_next_f(wr_ptr_r);
         end
         if (deq) begin
            rd_ptr_r <= ptr_next_f(rd_ptr_r);
         end
         // both at once keeps the count
         case ({enq, deq})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
      end
   end

   // storage
   always_ff @(posedge clk_i) begin
      if (enq) begin
         mem_r[wr_ptr_r] <= data_i;
      end
   end

endmodule

//--- design/mesh_link_ingress.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mesh link ingress
// stub masking and ready or credit return per port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mesh_link_ingress #(
   parameter int width_p = 16,
   parameter int fifo_els_p = 2,
   parameter logic [mesh_router_pkg::dirs_c-1:0] stub_p = '0,
   parameter logic [mesh_router_pkg::dirs_c-1:0] use_credits_p = '0
) (
   input  logic                                             clk_i,
   input  logic                                             reset_i,
   input  logic [mesh_router_pkg::dirs_c-1:0]               link_v_i,
   input  logic [mesh_router_pkg::dirs_c-1:0][width_p-1:0]  link_data_i,
   output logic [mesh_router_pkg::dirs_c-1:0]               link_ready_o,
   output logic [mesh_router_pkg::dirs_c-1:0]               fifo_v_o,
   output logic [mesh_router_pkg::dirs_c-1:0][width_p-1:0]  fifo_data_o,
   input  logic [mesh_router_pkg::dirs_c-1:0]               fifo_ready_i,
   input  logic [mesh_router_pkg::dirs_c-1:0]               fifo_yumi_i
);

   localparam int dirs_lp = mesh_router_pkg::dirs_c;
   localparam int cnt_w_lp = $clog2(fifo_els_p + 1);

   for (genvar i = 0; i < dirs_lp; i++) begin : g_port
      if (stub_p[i]) begin : g_stub
         // nothing enters a stubbed port
         assign fifo_v_o[i]     = 1'b0;
         assign fifo_data_o[i]  = '0;
         assign link_ready_o[i] = 1'b0;
      end else if (use_credits_p[i]) begin : g_credit
         logic                credit_r;
         logic [cnt_w_lp-1:0] held_r;
         logic                accept;

         // refuse words beyond the credits handed out
         assign fifo_v_o[i]     = link_v_i[i] & (held_r != cnt_w_lp'(fifo_els_p));
         assign fifo_data_o[i]  = link_data_i[i];
         assign link_ready_o[i] = credit_r;
         assign accept          = fifo_v_o[i] & fifo_ready_i[i];

         // one credit pulse per dequeue a cycle later
         always_ff @(posedge clk_i) begin
            if (!reset_i) begin
               credit_r <= 1'b0;
               held_r   <= '0;
            end else begin
               credit_r <= fifo_yumi_i[i];
               held_r   <= held_r + cnt_w_lp'(accept) - cnt_w_lp'(credit_r);
            end
         end
      end else begin : g_ready
         assign fifo_v_o[i]     = link_v_i[i];
         assign fifo_data_o[i]  = link_data_i[i];
         assign link_ready_o[i] = fifo_ready_i[i];
      end
   end

endmodule

//--- design/mesh_route_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mesh route arbiter
// xy route decode of fifo heads and round-robin
// output arbitration with grant hold on stall
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mesh_route_arbiter #(
   parameter int width_p = 16,
   parameter int x_cord_width_p = 3,
   parameter int y_cord_width_p = 3
) (
   input  logic                                             clk_i,
   input  logic                                             reset_i,
   input  logic [mesh_router_pkg::dirs_c-1:0]               v_i,
   input  logic [mesh_router_pkg::dirs_c-1:0][width_p-1:0]  data_i,
   output logic [mesh_router_pkg::dirs_c-1:0]               yumi_o,
   input  logic [x_cord_width_p-1:0]                        my_x_i,
   input  logic [y_cord_width_p-1:0]                        my_y_i,
   output logic [mesh_router_pkg::dirs_c-1:0]               v_o,
   output logic [mesh_router_pkg::dirs_c-1:0][width_p-1:0]  data_o,
   input  logic [mesh_router_pkg::dirs_c-1:0]               ready_i
);

   localparam int dirs_lp  = mesh_router_pkg::dirs_c;
   localparam int sel_w_lp = $clog2(dirs_lp);
   localparam int y_lsb_lp = mesh_router_pkg::y_lsb_f(x_cord_width_p);

   mesh_router_pkg::dir_t           route [dirs_lp];
   logic [dirs_lp-1:0]              req [dirs_lp];
   logic [dirs_lp-1:0][sel_w_lp-1:0] sel;
   logic [dirs_lp-1:0][sel_w_lp-1:0] last_r;
   logic [dirs_lp-1:0][sel_w_lp-1:0] hold_r;
   logic [dirs_lp-1:0]              lock_r;

   // first requester after the last winner
   function automatic logic [sel_w_lp-1:0] rr_pick_f(
      input logic [dirs_lp-1:0]  reqs,
      input logic [sel_w_lp-1:0] last
   );
      int                  idx;
      logic                found;
      logic [sel_w_lp-1:0] pick;
      found = 1'b0;
      pick  = last;
      for (int k = 1; k <= dirs_lp; k++) begin
         idx = int'(last) + k;
         if (idx >= dirs_lp) begin
            idx = idx - dirs_lp;
         end
         if (!found && reqs[idx]) begin
            pick  = sel_w_lp'(idx);
            found = 1'b1;
         end
      end
      return pick;
   endfunction

   // x first, then y, else local
   always_comb begin
      logic [x_cord_width_p-1:0] dest_x;
      logic [y_cord_width_p-1:0] dest_y;
      for (int i = 0; i < dirs_lp; i++) begin
         dest_x = data_i[i][mesh_router_pkg::x_lsb_c +: x_cord_width_p];
         dest_y = data_i[i][y_lsb_lp +: y_cord_width_p];
         if (dest_x < my_x_i) begin
            route[i] = mesh_router_pkg::w_dir;
         end else if (dest_x > my_x_i) begin
            route[i] = mesh_router_pkg::e_dir;
         end else if (dest_y < my_y_i) begin
            route[i] = mesh_router_pkg::n_dir;
         end else if (dest_y > my_y_i) begin
            route[i] = mesh_router_pkg::s_dir;
         end else begin
            route[i] = mesh_router_pkg::p_dir;
         end
      end
   end

   // request matrix, indexed output then input
   always_comb begin
      for (int o = 0; o < dirs_lp; o++) begin
         for (int i = 0; i < dirs_lp; i++) begin
            req[o][i] = v_i[i] && (route[i] == mesh_router_pkg::dir_t'(o));
         end
      end
   end

   for (genvar o = 0; o < dirs_lp; o++) begin : g_out
      logic [sel_w_lp-1:0] pick;

      assign pick      = rr_pick_f(req[o], last_r[o]);
      // a stalled output keeps its winner
      assign sel[o]    = lock_r[o] ? hold_r[o] : pick;
      assign v_o[o]    = req[o][sel[o]];
      assign data_o[o] = data_i[sel[o]];
   end

   // dequeue only on an output transfer
   always_comb begin
      yumi_o = '0;
      for (int o = 0; o < dirs_lp; o++) begin
         if (v_o[o] && ready_i[o]) begin
            yumi_o[sel[o]] = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!reset_i) begin
         lock_r <= '0;
         hold_r <= '0;
         // first search starts at P
         for (int o = 0; o < dirs_lp; o++) begin
            last_r[o] <= sel_w_lp'(dirs_lp - 1);
         end
      end else begin
         for (int o = 0; o < dirs_lp; o++) begin
            lock_r[o] <= v_o[o] & ~ready_i[o];
            hold_r[o] <= sel[o];
            if (v_o[o] && ready_i[o]) begin
               last_r[o] <= sel[o];
            end
         end
      end
   end

endmodule

//--- design/mesh_router_buffered.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// buffered mesh router tile
// ingress, five input fifos and xy route arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mesh_router_buffered #(
   parameter int width_p = 16,
   parameter int x_cord_width_p = 3,
   parameter int y_cord_width_p = 3,
   parameter int fifo_els_p = 2,
   // bit order P W E N S from bit 0
   parameter logic [mesh_router_pkg::dirs_c-1:0] stub_p = '0,
   parameter logic [mesh_router_pkg::dirs_c-1:0] use_credits_p = '0
) (
   input  logic                                             clk_i,
   input  logic                                             reset_i,
   input  logic [mesh_router_pkg::dirs_c-1:0]               link_v_i,
   input  logic [mesh_router_pkg::dirs_c-1:0][width_p-1:0]  link_data_i,
   output logic [mesh_router_pkg::dirs_c-1:0]               link_ready_o,
   output logic [mesh_router_pkg::dirs_c-1:0]               link_v_o,
   output logic [mesh_router_pkg::dirs_c-1:0][width_p-1:0]  link_data_o,
   input  logic [mesh_router_pkg::dirs_c-1:0]               link_ready_i,
   input  logic [x_cord_width_p-1:0]                        my_x_i,
   input  logic [y_cord_width_p-1:0]                        my_y_i
);

   localparam int dirs_lp = mesh_router_pkg::dirs_c;

   logic [dirs_lp-1:0]              in_v;
   logic [dirs_lp-1:0][width_p-1:0] in_data;
   logic [dirs_lp-1:0]              in_ready;
   logic [dirs_lp-1:0]              head_v;
   logic [dirs_lp-1:0][width_p-1:0] head_data;
   logic [dirs_lp-1:0]              head_yumi;

   mesh_link_ingress #(
      .width_p       (width_p),
      .fifo_els_p    (fifo_els_p),
      .stub_p        (stub_p),
      .use_credits_p (use_credits_p)
   ) u_mesh_link_ingress (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .link_v_i      (link_v_i),
      .link_data_i   (link_data_i),
      .link_ready_o  (link_ready_o),
      .fifo_v_o      (in_v),
      .fifo_data_o   (in_data),
      .fifo_ready_i  (in_ready),
      .fifo_yumi_i   (head_yumi)
   );

   // one buffer per input port
   for (genvar i = 0; i < dirs_lp; i++) begin : g_fifo
      mesh_input_fifo #(
         .width_p (width_p),
         .els_p   (fifo_els_p)
      ) u_mesh_input_fifo (
         .clk_i   (clk_i),
         .reset_i (reset_i),
         .v_i     (in_v[i]),
         .data_i  (in_data[i]),
         .ready_o (in_ready[i]),
         .v_o     (head_v[i]),
         .data_o  (head_data[i]),
         .yumi_i  (head_yumi[i])
      );
   end

   mesh_route_arbiter #(
      .width_p        (width_p),
      .x_cord_width_p (x_cord_width_p),
      .y_cord_width_p (y_cord_width_p)
   ) u_mesh_route_arbiter (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (head_v),
      .data_i  (head_data),
      .yumi_o  (head_yumi),
      .my_x_i  (my_x_i),
      .my_y_i  (my_y_i),
      .v_o     (link_v_o),
      .data_o  (link_data_o),
      .ready_i (link_ready_i)
   );

endmodule

//--- design/mesh_router_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mesh router package
// port indices, route type and flit field offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mesh_router_pkg;

   // five ports with the processor first
   localparam int dirs_c = 5;

   localparam int dir_p_c = 0;
   localparam int dir_w_c = 1;
   localparam int dir_e_c = 2;
   localparam int dir_n_c = 3;
   localparam int dir_s_c = 4;

   // route result of one flit
   typedef enum logic [2:0] {
      p_dir = 3'(dir_p_c),
      w_dir = 3'(dir_w_c),
      e_dir = 3'(dir_e_c),
      n_dir = 3'(dir_n_c),
      s_dir = 3'(dir_s_c)
   } dir_t;

   // destination x sits at the bottom of the flit
   localparam int x_lsb_c = 0;

   // destination y right above x
   function automatic int y_lsb_f(input int x_w);
      return x_lsb_c + x_w;
   endfunction

   // payload above both coordinates
   function automatic int payload_lsb_f(input int x_w, input int y_w);
      return y_lsb_f(x_w) + y_w;
   endfunction

endpackage

//--- mesh_router_buffered.f
design/mesh_router_pkg.sv
design/mesh_link_ingress.sv
design/mesh_input_fifo.sv
design/mesh_route_arbiter.sv
design/mesh_router_buffered.sv
testbench/mesh_router_buffered_props.sv
testbench/mesh_router_buffered_tb.sv

//--- testbench/mesh_router_buffered_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// route arbiter properties
// dequeue, stall and reset rules of the outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mesh_router_buffered_props #(
   parameter int width_p = 16
) (
   input logic                                            clk_i,
   input logic                                            reset_i,
   input logic [mesh_router_pkg::dirs_c-1:0]              head_v_i,
   input logic [mesh_router_pkg::dirs_c-1:0]              yumi_i,
   input logic [mesh_router_pkg::dirs_c-1:0]              out_v_i,
   input logic [mesh_router_pkg::dirs_c-1:0][width_p-1:0] out_data_i,
   input logic [mesh_router_pkg::dirs_c-1:0]              out_ready_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // each head is taken by at most one output
   yumi_once_a: assert property (@(posedge clk_i) disable iff (!reset_i)
      $countones(yumi_i) == $countones(out_v_i & out_ready_i))
      else $error("one fifo head taken by two outputs");

   yumi_valid_a: assert property (@(posedge clk_i) disable iff (!reset_i)
      (yumi_i & ~head_v_i) == '0)
      else $error("yumi on an empty fifo");

   reset_quiet_a: assert property (@(posedge clk_i) !reset_i |=> out_v_i == '0)
      else $error("output valid during reset");

   for (genvar o = 0; o < mesh_router_pkg::dirs_c; o++) begin : g_stall
      stall_hold_a: assert property (@(posedge clk_i) disable iff (!reset_i)
         out_v_i[o] && !out_ready_i[o] |=> out_v_i[o] && $stable(out_data_i[o]))
         else $error("output %0d changed while stalled", o);
   end

endmodule

//--- testbench/mesh_router_buffered_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mesh router testbench
// file-driven flits, random back-pressure, scoreboard
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mesh_router_buffered_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int dirs_lp    = mesh_router_pkg::dirs_c;
   localparam int n_lp       = mesh_router_pkg::dir_n_c;
   localparam int s_lp       = mesh_router_pkg::dir_s_c;
   localparam int width_lp   = 16;
   localparam int cord_w_lp  = 3;
   localparam int tag_lsb_lp = 2 * cord_w_lp;
   localparam int els_lp     = 2;
   localparam int my_x_lp    = 2;
   localparam int my_y_lp    = 2;
   // tag 3ff never appears in the test file
   localparam logic [width_lp-1:0] junk_flit_lp = 16'hffd2;

   logic                               clk;
   logic                               reset_n;
   logic [dirs_lp-1:0]                 link_v_in;
   logic [dirs_lp-1:0][width_lp-1:0]   link_data_in;
   logic [dirs_lp-1:0]                 link_ready_out;
   logic [dirs_lp-1:0]                 link_v_out;
   logic [dirs_lp-1:0][width_lp-1:0]   link_data_out;
   logic [dirs_lp-1:0]                 link_ready_in;
   logic [cord_w_lp-1:0]               my_x;
   logic [cord_w_lp-1:0]               my_y;

   string                 name_a [$];
   logic [width_lp-1:0]   flit_a [$];
   int                    src_a [$];
   mesh_router_pkg::dir_t dst_a [$];
   int                    idx_of_tag [int];
   int                    pend_q [dirs_lp][$];
   int                    head_q [dirs_lp][$];
   int                    exp_q [dirs_lp][dirs_lp][$];
   int                    wait_cnt [dirs_lp][dirs_lp] = '{default: 0};
   int                    credits, pulses, sent_n, delivered, n_flits, cycles, limit;
   logic [31:0]           lcg_state;
   logic                  started, done;

   mesh_router_buffered #(
      .width_p        (width_lp),
      .x_cord_width_p (cord_w_lp),
      .y_cord_width_p (cord_w_lp),
      .fifo_els_p     (els_lp),
      .stub_p         (5'b10000),
      .use_credits_p  (5'b01000)
   ) u_mesh_router_buffered (
      .clk_i        (clk),
      .reset_i      (reset_n),
      .link_v_i     (link_v_in),
      .link_data_i  (link_data_in),
      .link_ready_o (link_ready_out),
      .link_v_o     (link_v_out),
      .link_data_o  (link_data_out),
      .link_ready_i (link_ready_in),
      .my_x_i       (my_x),
      .my_y_i       (my_y)
   );

   bind mesh_route_arbiter mesh_router_buffered_props #(
      .width_p (width_p)
   ) u_props (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .head_v_i    (v_i),
      .yumi_i      (yumi_o),
      .out_v_i     (v_o),
      .out_data_i  (data_o),
      .out_ready_i (ready_i)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // x first, then y, own tile goes local
   function automatic mesh_router_pkg::dir_t xy_route(input int dx, input int dy);
      if (dx < my_x_lp) begin
         return mesh_router_pkg::w_dir;
      end else if (dx > my_x_lp) begin
         return mesh_router_pkg::e_dir;
      end else if (dy < my_y_lp) begin
         return mesh_router_pkg::n_dir;
      end else if (dy > my_y_lp) begin
         return mesh_router_pkg::s_dir;
      end
      return mesh_router_pkg::p_dir;
   endfunction

   task automatic stop_run();
      $display("*** FAILED ***");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act) begin
         $display("mismatch %s expected %0h actual %0h", name, exp, act);
         stop_run();
      end
   endtask

   task automatic read_tests();
      int    fd, n, port, dx, dy, tag;
      string line, name;
      fd = $fopen("testbench/mesh_router_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open the test file");
         stop_run();
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%s %d %d %d %h", name, port, dx, dy, tag);
            if (n != 5 || port >= s_lp) begin
               $display("badly formed line in the test file: %s", line);
               stop_run();
            end
            idx_of_tag[tag] = name_a.size();
            pend_q[port].push_back(name_a.size());
            name_a.push_back(name);
            flit_a.push_back({tag[9:0], dy[2:0], dx[2:0]});
            src_a.push_back(port);
            dst_a.push_back(xy_route(dx, dy));
         end
      end
      $fclose(fd);
   endtask

   // stimulus and back-pressure launched on the rising edge
   always @(posedge clk) begin
      if (started) begin
         cycles++;
         if (cycles > limit) begin
            $display("timeout: flits still missing after %0d cycles", limit);
            stop_run();
         end
         lcg_state = lcg_next(lcg_state);
         for (int i = 0; i < dirs_lp; i++) begin
            link_ready_in[i] <= |lcg_state[16 + 2 * i +: 2];
            if (i == s_lp) begin
               link_v_in[i]    <= lcg_state[27];
               link_data_in[i] <= junk_flit_lp;
            end else if (pend_q[i].size() > 0 && (i != n_lp || credits > 0)) begin
               link_v_in[i]    <= 1'b1;
               link_data_in[i] <= flit_a[pend_q[i][0]];
            end else begin
               link_v_in[i] <= 1'b0;
            end
         end
      end
   end

   // scoreboard sampled on the falling edge where all is stable
   always @(negedge clk) begin : monitor
      int                 got [dirs_lp];
      int                 src, e, tag;
      logic [dirs_lp-1:0] xfer;
      if (started) begin
         check_value("stubbed s ready", 0, link_ready_out[s_lp]);
         xfer = link_v_out & link_ready_in;
         for (int o = 0; o < dirs_lp; o++) begin
            if (xfer[o]) begin
               tag = int'(link_data_out[o][width_lp-1:tag_lsb_lp]);
               if (!idx_of_tag.exists(tag)) begin
                  $display("output %0d sent a flit that no test sent", o);
                  stop_run();
               end
               got[o] = idx_of_tag[tag];
               src    = src_a[got[o]];
               // heads still waiting on this output lose one more round
               for (int j = 0; j < dirs_lp; j++) begin
                  if (j == src) begin
                     wait_cnt[o][j] = 0;
                  end else if (head_q[j].size() > 0 && dst_a[head_q[j][0]] == o) begin
                     wait_cnt[o][j]++;
                     check_value($sformatf("input %0d fair share of output %0d", j, o),
                                 1, wait_cnt[o][j] <= 4);
                  end else begin
                     wait_cnt[o][j] = 0;
                  end
               end
            end
         end
         for (int o = 0; o < dirs_lp; o++) begin
            if (xfer[o]) begin
               src = src_a[got[o]];
               if (exp_q[src][o].size() == 0) begin
                  $display("flit of test %s left on port %0d where none was due",
                           name_a[got[o]], o);
                  stop_run();
               end
               e = exp_q[src][o].pop_front();
               check_value(name_a[e], flit_a[e], link_data_out[o]);
               // fifo order of the source
               check_value(name_a[e], flit_a[head_q[src][0]], link_data_out[o]);
               void'(head_q[src].pop_front());
               delivered++;
            end
         end
         for (int i = 0; i < s_lp; i++) begin
            if (link_v_in[i] && (i == n_lp || link_ready_out[i])) begin
               e = pend_q[i].pop_front();
               head_q[i].push_back(e);
               exp_q[i][dst_a[e]].push_back(e);
               if (i == n_lp) begin
                  sent_n++;
                  credits--;
               end
            end
         end
         if (link_ready_out[n_lp]) begin
            credits++;
            pulses++;
         end
         check_value("n credit count in range", 1, credits >= 0 && credits <= els_lp);
         done = (delivered == n_flits);
      end
   end

   initial begin
      clk           = 1'b0;
      reset_n       = 1'b0;
      link_v_in     = '0;
      link_data_in  = '0;
      link_ready_in = '0;
      my_x          = cord_w_lp'(my_x_lp);
      my_y          = cord_w_lp'(my_y_lp);
      started       = 1'b0;
      done          = 1'b0;
      credits       = els_lp;
      pulses        = 0;
      sent_n        = 0;
      delivered     = 0;
      cycles        = 0;
      lcg_state     = 32'h61b756a8;
      read_tests();
      n_flits = name_a.size();
      limit   = 40 * n_flits + 100;
      repeat (4) @(posedge clk);
      reset_n <= 1'b1;
      @(negedge clk);
      check_value("outputs idle after reset", 0, link_v_out);
      check_value("n credit low after reset", 0, link_ready_out[n_lp]);
      check_value("p ready after reset", 1, link_ready_out[mesh_router_pkg::dir_p_c]);
      started = 1'b1;
      wait (done);
      // last credit pulse trails the last dequeue by one cycle
      repeat (2) @(negedge clk);
      check_value("credit pulses on n", sent_n, pulses);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

//--- testbench/mesh_router_tests.txt
# columns: test name, input port (0 P, 1 W, 2 E, 3 N), dest x, dest y, payload tag (hex)
# the tile sits at x 2, y 2; the S input is stubbed and has no lines
local_from_p    0 2 2 001
local_from_w    1 2 2 002
local_from_e    2 2 2 003
local_from_n    3 2 2 004
west_from_p     0 0 2 010
west_from_e     2 1 5 011
west_from_n     3 1 0 012
east_from_p     0 3 2 020
east_from_w     1 7 7 021
east_from_n     3 5 1 022
north_from_p    0 2 1 030
north_from_w    1 2 0 031
north_from_e    2 2 1 032
south_from_p    0 2 3 040
south_from_w    1 2 7 041
south_from_e    2 2 4 042
south_from_n    3 2 6 043
x_first_w       1 6 0 050
x_first_e       2 0 7 051
x_first_n       3 4 4 052
crowd_e_p0      0 4 2 100
crowd_e_w0      1 4 3 101
crowd_e_e0      2 4 1 102
crowd_e_n0      3 4 2 103
crowd_e_p1      0 5 2 104
crowd_e_w1      1 5 0 105
crowd_e_e1      2 6 6 106
crowd_e_n1      3 7 2 107
crowd_e_p2      0 3 3 108
crowd_e_w2      1 3 5 109
crowd_e_e2      2 3 0 10a
crowd_e_n2      3 6 1 10b
mix_p0          0 1 1 200
mix_w0          1 2 5 201
mix_e0          2 2 2 202
mix_n0          3 0 0 203
mix_p1          0 2 0 204
mix_w1          1 3 2 205
mix_e1          2 1 3 206
mix_n1          3 2 3 207
